// ==== hw/vmod_data_pkg.sv ====
`default_nettype none

package vmod_data_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and modulus word width
  localparam int DATA_W  = 32;
  // Element count and index width
  localparam int INDEX_W = 16;

  ////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////

  // One element on its way to the engine
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] modulo;
    logic              last;
  } operand_t;

  // Remainder leaving the engine
  typedef struct packed {
    logic [DATA_W-1:0] rem;
    logic              last;
  } result_t;

endpackage

`default_nettype wire

// ==== hw/vmod_ctrl_pkg.sv ====
`default_nettype none

package vmod_ctrl_pkg;

  ////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////

  // Idle waits for start, stream takes words
  typedef enum logic [0:0] {
    SEQ_IDLE   = 1'b0,
    SEQ_STREAM = 1'b1
  } seq_state_t;

  ////////////////////////////////////////
  // Engine FSM
  ////////////////////////////////////////

  // Pop, iterate DATA_W steps, emit one pulse
  typedef enum logic [1:0] {
    ENG_IDLE = 2'd0,
    ENG_CALC = 2'd1,
    ENG_EMIT = 2'd2
  } eng_state_t;

endpackage

`default_nettype wire

// ==== hw/vector_mod_sequencer.sv ====
`default_nettype none

module vector_mod_sequencer
  import vmod_data_pkg::*;
  import vmod_ctrl_pkg::*;
(
  input  wire logic               CLK,
  input  wire logic               RST,
  // Job control
  input  wire logic               start,
  input  wire logic [INDEX_W-1:0] size,
  input  wire logic [DATA_W-1:0]  modulo,
  // Input stream
  input  wire logic               in_valid,
  input  wire logic [DATA_W-1:0]  in_data,
  output logic                    in_ready,
  output logic                    busy,
  // FIFO write side
  input  wire logic               full,
  output logic                    push,
  output operand_t                push_data
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  seq_state_t         state_q;
  logic [INDEX_W-1:0] count_q;
  logic [INDEX_W-1:0] size_q;
  logic [DATA_W-1:0]  modulo_q;

  logic start_ok;
  logic last_elem;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Only an idle sequencer takes a job, and never an empty one
  assign start_ok = (state_q == SEQ_IDLE) && start && (size != '0);

  assign busy     = (state_q == SEQ_STREAM);
  // Stall the host while the FIFO has no room
  assign in_ready = busy && !full;
  assign push     = in_valid && in_ready;

  // Final element of the vector
  assign last_elem = (count_q == size_q - INDEX_W'(1));

  // Operand goes to the FIFO in the accept cycle
  always_comb begin
    push_data.data   = in_data;
    push_data.modulo = modulo_q;
    push_data.last   = last_elem;
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= SEQ_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (start_ok) begin
            count_q <= '0;
            state_q <= SEQ_STREAM;
          end
        end
        SEQ_STREAM: begin
          if (push) begin
            count_q <= count_q + INDEX_W'(1);
            // Back to idle once the last word went in
            if (last_elem) begin
              state_q <= SEQ_IDLE;
            end
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // Job parameters, held for the whole vector
  always_ff @(posedge CLK) begin
    if (start_ok) begin
      size_q   <= size;
      modulo_q <= modulo;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_fifo.sv ====
`default_nettype none

module operand_fifo
  import vmod_data_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic     CLK,
  input  wire logic     RST,
  // Write side
  input  wire logic     push,
  input  operand_t      push_data,
  // Read side
  input  wire logic     pop,
  output operand_t      pop_data,
  // Status
  output logic          full,
  output logic          empty
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Address bits, pointers carry one more for wrap
  localparam int AW = $clog2(FIFO_DEPTH);

  operand_t      mem [FIFO_DEPTH];
  logic [AW:0]   wr_ptr_q;
  logic [AW:0]   rd_ptr_q;

  logic          same_addr;
  logic          same_wrap;

  ////////////////////////////////////////
  // Flags
  ////////////////////////////////////////

  assign same_addr = (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign same_wrap = (wr_ptr_q[AW] == rd_ptr_q[AW]);

  // Same slot, same lap means nothing stored
  assign empty = same_addr && same_wrap;
  // Same slot, writer one lap ahead
  assign full  = same_addr && !same_wrap;

  // Head of queue, straight from storage
  assign pop_data = mem[rd_ptr_q[AW-1:0]];

  ////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      // Producer checks full before pushing
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // Consumer checks empty before popping
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr_q[AW-1:0]] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scalar_mod_engine.sv ====
`default_nettype none

module scalar_mod_engine
  import vmod_data_pkg::*;
  import vmod_ctrl_pkg::*;
(
  input  wire logic CLK,
  input  wire logic RST,
  // FIFO read side
  input  wire logic empty,
  input  operand_t  pop_data,
  output logic      pop,
  // Result stream
  output result_t   result,
  output logic      result_valid
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  localparam int STEP_W = $clog2(DATA_W);

  eng_state_t        state_q;
  logic [STEP_W-1:0] step_q;
  logic              last_q;

  // Datapath
  logic [DATA_W-1:0] dividend_q;
  logic [DATA_W-1:0] divisor_q;
  logic [DATA_W-1:0] rem_q;

  logic [DATA_W:0]   shifted;
  logic [DATA_W:0]   diff;
  logic [DATA_W-1:0] next_rem;

  ////////////////////////////////////////
  // Restoring step
  ////////////////////////////////////////

  // Next dividend bit into the partial remainder
  // One extra bit so a full-width modulus cannot overflow
  assign shifted = {rem_q, dividend_q[DATA_W-1]};
  assign diff    = shifted - {1'b0, divisor_q};

  // Subtract only when it fits
  // modulus 0 always "fits" and rem just collects the data bits
  assign next_rem = (shifted >= {1'b0, divisor_q}) ? diff[DATA_W-1:0]
                                                   : shifted[DATA_W-1:0];

  // Take a new operand whenever idle and one is waiting
  assign pop = (state_q == ENG_IDLE) && !empty;

  assign result_valid = (state_q == ENG_EMIT);
  assign result.rem   = rem_q;
  assign result.last  = last_q;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= ENG_IDLE;
      step_q  <= '0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          if (pop) begin
            step_q  <= '0;
            last_q  <= pop_data.last;
            state_q <= ENG_CALC;
          end
        end
        ENG_CALC: begin
          step_q <= step_q + STEP_W'(1);
          // Exactly DATA_W iterations
          if (step_q == STEP_W'(DATA_W - 1)) begin
            state_q <= ENG_EMIT;
          end
        end
        ENG_EMIT: begin
          // One-cycle result pulse
          state_q <= ENG_IDLE;
        end
        default: begin
          state_q <= ENG_IDLE;
        end
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge CLK) begin
    if (pop) begin
      dividend_q <= pop_data.data;
      divisor_q  <= pop_data.modulo;
      rem_q      <= '0;
    end else if (state_q == ENG_CALC) begin
      dividend_q <= dividend_q << 1;
      rem_q      <= next_rem;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vector_mod_top.sv ====
`default_nettype none

module vector_mod_top
  import vmod_data_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic               CLK,
  input  wire logic               RST,
  // Job control
  input  wire logic               start,
  input  wire logic [INDEX_W-1:0] size,
  input  wire logic [DATA_W-1:0]  modulo,
  // Input stream
  input  wire logic               in_valid,
  input  wire logic [DATA_W-1:0]  in_data,
  output logic                    in_ready,
  output logic                    busy,
  // Output stream, no back-pressure
  output logic                    out_valid,
  output logic [DATA_W-1:0]       out_data,
  output logic                    out_last,
  output logic                    done
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Sequencer to FIFO
  logic     push;
  operand_t push_data;
  logic     full;

  // FIFO to engine
  logic     pop;
  operand_t pop_data;
  logic     empty;

  // Engine results
  result_t  result;
  logic     result_valid;

  ////////////////////////////////////////
  // Output mapping
  ////////////////////////////////////////

  assign out_valid = result_valid;
  assign out_data  = result.rem;
  assign out_last  = result.last;
  // Final result of a vector
  assign done      = result_valid && result.last;

  // Producer
  vector_mod_sequencer u_seq (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size      (size),
    .modulo    (modulo),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .busy      (busy),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  // Buffer between input and computation
  operand_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  // Consumer
  scalar_mod_engine u_eng (
    .CLK          (CLK),
    .RST          (RST),
    .empty        (empty),
    .pop_data     (pop_data),
    .pop          (pop),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// ==== sim/tb_vector_mod.sv ====
`default_nettype none

module tb_vector_mod
  import vmod_data_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Job table
  ////////////////////////////////////////

  // One row of stimulus
  typedef struct packed {
    logic [DATA_W-1:0]  modulo;
    logic [DATA_W-1:0]  mask;
    logic [INDEX_W-1:0] size;
    logic               overlap;
    logic               poke;
  } job_t;

  localparam int NUM_JOBS = 7;
  localparam int TIMEOUT  = 2000;

  job_t jobs [NUM_JOBS];

  // DUT ports
  logic               CLK;
  logic               RST;
  logic               start;
  logic [INDEX_W-1:0] size;
  logic [DATA_W-1:0]  modulo;
  logic               in_valid;
  logic [DATA_W-1:0]  in_data;
  logic               in_ready;
  logic               busy;
  logic               out_valid;
  logic [DATA_W-1:0]  out_data;
  logic               out_last;
  logic               done;

  // Scoreboard state
  result_t     exp_q [$];
  result_t     mon_exp;
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          jobs_done;
  int          job_results;
  logic        saw_stall;

  vector_mod_top uut (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size      (size),
    .modulo    (modulo),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .busy      (busy),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .done      (done)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic job_t make_job(input logic [DATA_W-1:0] m, input logic [DATA_W-1:0] k,
                                    input int n, input logic ov, input logic pk);
    job_t j;
    j.modulo  = m;
    j.mask    = k;
    j.size    = INDEX_W'(n);
    j.overlap = ov;
    j.poke    = pk;
    return j;
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per data bit
  task automatic next_word(output logic [DATA_W-1:0] w);
    w = '0;
    for (int b = 0; b < DATA_W; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[DATA_W-2:0], lfsr[0]};
    end
  endtask

  // Reference remainder, zero modulus passes data through
  function automatic logic [DATA_W-1:0] ref_rem(input logic [DATA_W-1:0] d,
                                                input logic [DATA_W-1:0] m);
    return (m == '0) ? d : d % m;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t ns: %s", $time, why);
    $display("FAIL: see errors above");
    $finish;
  endtask

  ////////////////////////////////////////
  // Wait loops
  ////////////////////////////////////////

  task automatic wait_ready();
    int t;
    t = 0;
    while (!in_ready) begin
      @(negedge CLK);
      t++;
      if (t > TIMEOUT) abort_run("in_ready never came back");
    end
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (busy) begin
      @(negedge CLK);
      t++;
      if (t > TIMEOUT) abort_run("busy never fell");
    end
  endtask

  task automatic wait_drain(input int limit);
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      @(negedge CLK);
      t++;
      if (t > limit) abort_run("results stopped arriving");
    end
  endtask

  ////////////////////////////////////////
  // Job driver
  ////////////////////////////////////////

  task automatic run_job(input int idx);
    job_t              j;
    logic [DATA_W-1:0] w;
    result_t           e;
    j = jobs[idx];
    // Back-to-back jobs skip the drain
    if (!j.overlap) wait_drain(TIMEOUT);
    wait_idle();
    start  = 1'b1;
    size   = j.size;
    modulo = j.modulo;
    @(negedge CLK);
    start = 1'b0;
    check_value("busy after start", busy, 1);
    for (int i = 0; i < int'(j.size); i++) begin
      next_word(w);
      w = w & j.mask;
      e.rem  = ref_rem(w, j.modulo);
      e.last = (i == int'(j.size) - 1);
      exp_q.push_back(e);
      // in_valid stays high across words
      in_valid = 1'b1;
      in_data  = w;
      wait_ready();
      // Start with the last word must be ignored, so busy still falls
      if (j.poke && i == int'(j.size) - 1) begin
        start  = 1'b1;
        size   = INDEX_W'(5);
        modulo = 32'd3;
      end
      @(negedge CLK);
      start = 1'b0;
      if (j.poke && i == int'(j.size) - 1) check_value("busy after ignored start", busy, 0);
    end
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  // Outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (busy && in_valid && !in_ready) saw_stall = 1'b1;
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("result %h arrived at %0t ns with nothing expected", out_data, $time);
        end else begin
          mon_exp = exp_q.pop_front();
          check_value("out_data", out_data, mon_exp.rem);
          check_value("out_last", out_last, mon_exp.last);
          check_value("done", done, mon_exp.last);
          job_results++;
          // Job boundary as the DUT marks it
          if (out_last && jobs_done < NUM_JOBS) begin
            check_value("result count", job_results, jobs[jobs_done].size);
            $display("job %0d finished: modulo %h, %0d results", jobs_done,
                     jobs[jobs_done].modulo, job_results);
            jobs_done++;
            job_results = 0;
          end
        end
      end else begin
        check_value("done without out_valid", done, 0);
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int t;
    CLK         = 1'b0;
    RST         = 1'b1;
    start       = 1'b0;
    size        = '0;
    modulo      = '0;
    in_valid    = 1'b0;
    in_data     = '0;
    lfsr        = 32'ha56f;
    errors      = 0;
    checks      = 0;
    jobs_done   = 0;
    job_results = 0;
    saw_stall   = 1'b0;

    // modulo, data mask, size, overlap, bad start
    jobs[0] = make_job(32'd7,          32'hffff_ffff, 5, 1'b0, 1'b0);
    jobs[1] = make_job(32'd1,          32'hffff_ffff, 3, 1'b1, 1'b1);
    jobs[2] = make_job(32'd0,          32'hffff_ffff, 4, 1'b0, 1'b0);
    jobs[3] = make_job(32'h0012_3457,  32'h0000_ffff, 4, 1'b1, 1'b0);
    jobs[4] = make_job(32'hffff_fff1,  32'hffff_ffff, 6, 1'b1, 1'b1);
    jobs[5] = make_job(32'h0000_1000,  32'hffff_ffff, 8, 1'b1, 1'b0);
    jobs[6] = make_job(32'd13,         32'hffff_ffff, 1, 1'b0, 1'b0);

    repeat (5) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    check_value("busy after reset", busy, 0);
    check_value("in_ready after reset", in_ready, 0);
    check_value("out_valid after reset", out_valid, 0);
    check_value("done after reset", done, 0);
    $display("reset values checked");

    // Empty job must not start
    start  = 1'b1;
    size   = '0;
    modulo = 32'd5;
    @(negedge CLK);
    start = 1'b0;
    check_value("busy after zero-size start", busy, 0);
    repeat (3) @(negedge CLK);
    check_value("busy stays low", busy, 0);
    $display("zero-size start checked");

    for (int n = 0; n < NUM_JOBS; n++) begin
      run_job(n);
    end

    // Let everything drain
    t = 0;
    while (jobs_done < NUM_JOBS) begin
      @(negedge CLK);
      t++;
      if (t > 5 * TIMEOUT) abort_run("not every job reported its last result");
    end
    // Catch any stray results
    repeat (100) @(negedge CLK);
    check_value("leftover expected results", exp_q.size(), 0);
    check_value("in_ready stall seen", saw_stall, 1);
    $display("back-pressure checked");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hw/vmod_data_pkg.sv
hw/vmod_ctrl_pkg.sv
hw/vector_mod_sequencer.sv
hw/operand_fifo.sv
hw/scalar_mod_engine.sv
hw/vector_mod_top.sv
sim/tb_vector_mod.sv

// ==== Makefile ====
TOP = tb_vector_mod

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
